// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSI-2 receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module tbCsiRx -f tb.f -Mdir "$BUILD_DIR" -o simTb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$BUILD_DIR/simTb" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
	echo "Simulation did not run to completion"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== src/csiDualClkFifo.sv ====
/* Dual-clock FIFO, Gray pointers through two-flop synchronizers.
   pFifoDepth must be a power of two, at least 4. Writes while full are dropped */
`default_nettype none

module csiDualClkFifo #(
	parameter int pFifoDepth = 1024
) (
	// Write side, byte clock
	input  wire										wordClk,
	input  wire										qnHsRst,
	input  wire [csiProtoPkg::FifoWordBits-1:0]		fifoWrData,
	input  wire										fifoWrEn,
	output logic									fifoFull,
	// Read side, system clock
	input  wire										iSCLK,
	input  wire										fifoRdEn,
	output logic [csiProtoPkg::FifoWordBits-1:0]	fifoRdData,
	output logic									fifoRdValid,
	output logic									fifoEmpty
);
	import csiProtoPkg::*;

	localparam int AddrBits	= $clog2(pFifoDepth);
	localparam int PtrBits	= AddrBits + 1;				// Extra wrap bit

	logic [FifoWordBits-1:0]	fifoMem [pFifoDepth];
	logic [PtrBits-1:0]			wrBin, wrBinNext, wrGray;
	logic [PtrBits-1:0]			rdBin, rdBinNext, rdGray;
	logic [PtrBits-1:0]			rdGraySync0, rdGraySync1;	// Read ptr in write domain
	logic [PtrBits-1:0]			wrGraySync0, wrGraySync1;	// Write ptr in read domain
	logic						wrAccept, rdAccept;

	function automatic logic [PtrBits-1:0] toGray(input logic [PtrBits-1:0] binVal);
		return binVal ^ (binVal >> 1);
	endfunction

	// ----------------------------------------
	// Write domain
	// ----------------------------------------
	assign wrAccept		= fifoWrEn & ~fifoFull;			// Drop on full
	assign wrBinNext	= wrBin + 1'b1;
	// Full when top two Gray bits differ, rest equal
	assign fifoFull		= (wrGray == {~rdGraySync1[PtrBits-1 -: 2], rdGraySync1[PtrBits-3:0]});

	always_ff @(posedge wordClk)
	begin
		if (wrAccept)
			fifoMem[wrBin[AddrBits-1:0]] <= fifoWrData;
	end

	always_ff @(posedge wordClk, negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			wrBin		<= '0;
			wrGray		<= '0;
			rdGraySync0	<= '0;
			rdGraySync1	<= '0;
		end
		else
		begin
			if (wrAccept)
			begin
				wrBin	<= wrBinNext;
				wrGray	<= toGray(wrBinNext);
			end
			rdGraySync0	<= rdGray;						// Two-flop sync
			rdGraySync1	<= rdGraySync0;
		end
	end

	// ----------------------------------------
	// Read domain
	// ----------------------------------------
	assign fifoEmpty	= (rdGray == wrGraySync1);
	assign rdAccept		= fifoRdEn & ~fifoEmpty;
	assign rdBinNext	= rdBin + 1'b1;

	always_ff @(posedge iSCLK)
	begin
		if (rdAccept)
			fifoRdData <= fifoMem[rdBin[AddrBits-1:0]];	// Registered read
	end

	always_ff @(posedge iSCLK, negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rdBin		<= '0;
			rdGray		<= '0;
			wrGraySync0	<= '0;
			wrGraySync1	<= '0;
			fifoRdValid	<= 1'b0;
		end
		else
		begin
			if (rdAccept)
			begin
				rdBin	<= rdBinNext;
				rdGray	<= toGray(rdBinNext);
			end
			wrGraySync0	<= wrGray;
			wrGraySync1	<= wrGraySync0;
			fifoRdValid	<= rdAccept;					// Data one cycle later
		end
	end

	// Overflowing word leaves the write pointer where it was
	assert property (@(posedge wordClk) disable iff (!qnHsRst) fifoFull |=> $stable(wrBin))
		else $error("FIFO write accepted while full");

	assert property (@(posedge iSCLK) disable iff (!qnHsRst) fifoRdValid |-> !$past(fifoEmpty))
		else $error("FIFO read data after empty cycle");

endmodule : csiDualClkFifo

`default_nettype wire

// ==== src/csiHeaderParser.sv ====
/* Packet header decode and payload steering. ECC is passed through unchecked.
   Types up to LongPacketMin are short packets without payload */
`default_nettype none

module csiHeaderParser (
	input  wire										iSCLK,
	input  wire										qnHsRst,
	input  wire [csiProtoPkg::FifoWordBits-1:0]		fifoRdData,
	input  wire										fifoRdValid,
	input  wire										fifoEmpty,
	input  wire										lastWord,	// From line counter
	output logic									fifoRdEn,
	output logic									cntClear,
	output logic									cntStep,
	output logic [15:0]								wordCnt,
	output logic [csiRxCfgPkg::PixelBits-1:0]		pixel,
	output logic [5:0]								dataType,
	output logic [1:0]								virtChan,
	output logic [7:0]								ecc,
	output logic									pixelValid,
	output logic									lineEnd
);
	import csiProtoPkg::*;
	import csiRxCfgPkg::*;

	ParseState	state, nextState;
	LaneWord	rdWord;											// Current FIFO word
	logic		rdSync;											// Marker flag
	logic		isLong;
	logic		fwdWord;										// Payload word accepted

	// ----------------------------------------
	// Decode helpers
	// ----------------------------------------
	assign rdWord	= fifoRdData[FifoWordBits-2:0];
	assign rdSync	= fifoRdData[FifoWordBits-1];
	assign fifoRdEn	= ~fifoEmpty;								// No back-pressure
	assign isLong	= (dataType > LongPacketMin);
	// First payload word can already arrive during typeCheck
	assign fwdWord	= fifoRdValid & ((state == payload) | ((state == typeCheck) & isLong));
	assign cntStep	= fwdWord;
	assign cntClear	= (state == head1) & fifoRdValid;			// Count zero before payload

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_comb
	begin
		nextState = state;
		case (state)
			idle:		if (fifoRdValid && rdSync) nextState = head0;	// Skip until marker
			head0:		if (fifoRdValid) nextState = head1;
			head1:		if (fifoRdValid) nextState = typeCheck;
			typeCheck:
			begin
				if (isLong)
					nextState = (fwdWord && lastWord) ? idle : payload;
				else if (fifoRdValid && rdSync)
					nextState = head0;							// Next packet right behind
				else
					nextState = idle;
			end
			payload:	if (fwdWord && lastWord) nextState = idle;
			default:	nextState = idle;
		endcase
	end

	always_ff @(posedge iSCLK, negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			state		<= idle;
			pixelValid	<= 1'b0;
			lineEnd		<= 1'b0;
		end
		else
		begin
			state		<= nextState;
			pixelValid	<= fwdWord;
			lineEnd		<= fwdWord & lastWord;					// With last pixel
		end
	end

	// ----------------------------------------
	// Header fields and pixel data
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if ((state == head0) && fifoRdValid)
		begin
			virtChan		<= rdWord.header.loByte.virtChan;
			dataType		<= rdWord.header.loByte.dataType;
			wordCnt[7:0]	<= rdWord.header.hiByte;			// WC LSB
		end
		if ((state == head1) && fifoRdValid)
		begin
			wordCnt[15:8]	<= rdWord.header.loByte;			// WC MSB
			ecc				<= rdWord.header.hiByte;
		end
		if (fwdWord)
			pixel <= PixelBits'(rdWord.pixels);				// Zero-extended pair
	end

	assert property (@(posedge iSCLK) disable iff (!qnHsRst)
		state inside {idle, head0, head1, typeCheck, payload})
		else $error("Parser state illegal");

endmodule : csiHeaderParser

`default_nettype wire

// ==== src/csiLaneCapture.sv ====
/* Byte clock capture of two deskewed, aligned D-PHY lanes.
   A sync cycle is written as its own marker word */
`default_nettype none

module csiLaneCapture (
	input  wire										wordClk,	// D-PHY byte clock
	input  wire										qnHsRst,
	input  wire [7:0]								lane0Data,
	input  wire [7:0]								lane1Data,
	input  wire										laneValid,	// HS data valid
	input  wire										laneSync,	// HS sync seen
	output logic [csiProtoPkg::FifoWordBits-1:0]	fifoWrData,
	output logic									fifoWrEn
);
	import csiProtoPkg::*;

	LaneWord	rLaneWord;									// Merged byte pair
	logic		rSync;										// Sync level, registered

	// ----------------------------------------
	// Lane registers
	// ----------------------------------------
	always_ff @(posedge wordClk)
	begin
		rLaneWord.pixels <= {lane1Data, lane0Data};		// Lane 1 high byte
	end

	always_ff @(posedge wordClk, negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rSync		<= 1'b0;
			fifoWrEn	<= 1'b0;
		end
		else
		begin
			rSync		<= laneSync;
			fifoWrEn	<= laneValid | laneSync;		// Sync cycle as marker
		end
	end

	assign fifoWrData = {rSync, rLaneWord};				// Flag above data

endmodule : csiLaneCapture

`default_nettype wire

// ==== src/csiLineCounter.sv ====
/* Payload word counter against WC/2-1. Assumes an even word count of at least 2
   and no more than 2^pLineCntBits words per line */
`default_nettype none

module csiLineCounter #(
	parameter int pLineCntBits = 13
) (
	input  wire			iSCLK,
	input  wire			qnHsRst,
	input  wire			cntClear,
	input  wire			cntStep,
	input  wire [15:0]	wordCnt,								// Byte count from header
	output logic		lastWord
);
	logic [pLineCntBits-1:0]	count;						// Words seen this line
	logic [14:0]				countWide;
	logic [14:0]				targetCnt;					// Index of last word

	assign countWide	= 15'(count);
	assign targetCnt	= wordCnt[15:1] - 15'd1;			// Two bytes per word
	assign lastWord		= (countWide == targetCnt);

	// ----------------------------------------
	// Counter
	// ----------------------------------------
	always_ff @(posedge iSCLK, negedge qnHsRst)
	begin
		if (!qnHsRst)
			count <= '0;
		else if (cntClear)
			count <= '0;								// Clear wins over step
		else if (cntStep)
			count <= count + 1'b1;
	end

	// Parser must stop stepping at the last word
	assert property (@(posedge iSCLK) disable iff (!qnHsRst) cntStep |-> (countWide <= targetCnt))
		else $error("Line counter stepped past word count");

endmodule : csiLineCounter

`default_nettype wire

// ==== src/csiProtoPkg.sv ====
/* CSI-2 packet layout as seen after two-lane byte merge, lane 1 in the upper byte.
   ECC and CRC are carried only, never checked */
`default_nettype none

package csiProtoPkg;

	// ----------------------------------------
	// Packet header fields
	// ----------------------------------------
	localparam logic [5:0] LongPacketMin = 6'h13;	// Types above carry payload

	typedef struct packed
	{
		logic [1:0]	virtChan;						// Virtual channel
		logic [5:0]	dataType;						// Data type code
	} DataId;

	typedef struct packed
	{
		logic [7:0]	hiByte;							// WC LSB or ECC, lane 1
		DataId		loByte;							// DI or WC MSB, lane 0
	} HeaderPair;

	// ----------------------------------------
	// FIFO word
	// ----------------------------------------
	// One merged lane word, read as header bytes or as a pixel pair
	typedef union packed
	{
		HeaderPair		header;					// Header decode
		logic [15:0]	pixels;					// Payload, lane1 over lane0
	} LaneWord;

	localparam int FifoWordBits = 17;				// Sync flag plus LaneWord

endpackage : csiProtoPkg

`default_nettype wire

// ==== src/csiRxCfgPkg.sv ====
/* Receiver implementation constants and the header parser state encoding */
`default_nettype none

package csiRxCfgPkg;

	// ----------------------------------------
	// Output widths
	// ----------------------------------------
	localparam int PixelBits = 32;					// Pixel pair zero-extended

	// ----------------------------------------
	// Parser FSM
	// ----------------------------------------
	localparam int ParseStateBits = 3;

	typedef enum logic [ParseStateBits-1:0]
	{
		idle		= 3'd0,							// Wait for sync marker
		head0		= 3'd1,							// DI and WC LSB
		head1		= 3'd2,							// WC MSB and ECC
		typeCheck	= 3'd3,							// Short or long decision
		payload		= 3'd4							// Pixel forwarding
	} ParseState;

endpackage : csiRxCfgPkg

`default_nettype wire

// ==== src/csiRxDecoder.sv ====
/* Two-lane CSI-2 receiver top, byte clock in, pixels out on iSCLK.
   One active-low reset for both domains. FIFO full is not reported */
`default_nettype none

module csiRxDecoder #(
	parameter int pFifoDepth	= 1024,						// Power of two
	parameter int pLineCntBits	= 13						// Up to 8K words per line
) (
	input  wire										wordClk,
	input  wire										iSCLK,
	input  wire										qnHsRst,
	input  wire [7:0]								lane0Data,
	input  wire [7:0]								lane1Data,
	input  wire										laneValid,
	input  wire										laneSync,
	output wire [csiRxCfgPkg::PixelBits-1:0]		pixel,
	output wire [5:0]								dataType,
	output wire [1:0]								virtChan,
	output wire [15:0]								wordCnt,
	output wire [7:0]								ecc,
	output wire										pixelValid,
	output wire										lineEnd
);
	import csiProtoPkg::*;

	wire [FifoWordBits-1:0]	fifoWrData;						// Byte clock side
	wire					fifoWrEn;
	wire [FifoWordBits-1:0]	fifoRdData;						// System clock side
	wire					fifoRdEn, fifoRdValid, fifoEmpty;
	wire					cntClear, cntStep, lastWord;

	// ----------------------------------------
	// Byte clock domain
	// ----------------------------------------
	csiLaneCapture laneCapture (
		.wordClk(wordClk),			.qnHsRst(qnHsRst),
		.lane0Data(lane0Data),		.lane1Data(lane1Data),
		.laneValid(laneValid),		.laneSync(laneSync),
		.fifoWrData(fifoWrData),	.fifoWrEn(fifoWrEn)
	);

	csiDualClkFifo #(
		.pFifoDepth(pFifoDepth)
	) dualClkFifo (
		.wordClk(wordClk),			.qnHsRst(qnHsRst),
		.fifoWrData(fifoWrData),	.fifoWrEn(fifoWrEn),
		.fifoFull(),											// Overflow drops silently
		.iSCLK(iSCLK),				.fifoRdEn(fifoRdEn),
		.fifoRdData(fifoRdData),	.fifoRdValid(fifoRdValid),
		.fifoEmpty(fifoEmpty)
	);

	// ----------------------------------------
	// System clock domain
	// ----------------------------------------
	csiHeaderParser headerParser (
		.iSCLK(iSCLK),				.qnHsRst(qnHsRst),
		.fifoRdData(fifoRdData),	.fifoRdValid(fifoRdValid),
		.fifoEmpty(fifoEmpty),		.lastWord(lastWord),
		.fifoRdEn(fifoRdEn),		.cntClear(cntClear),
		.cntStep(cntStep),			.wordCnt(wordCnt),
		.pixel(pixel),				.dataType(dataType),
		.virtChan(virtChan),		.ecc(ecc),
		.pixelValid(pixelValid),	.lineEnd(lineEnd)
	);

	csiLineCounter #(
		.pLineCntBits(pLineCntBits)
	) lineCounter (
		.iSCLK(iSCLK),				.qnHsRst(qnHsRst),
		.cntClear(cntClear),		.cntStep(cntStep),
		.wordCnt(wordCnt),			.lastWord(lastWord)
	);

endmodule : csiRxDecoder

`default_nettype wire

// ==== tb.f ====
src/csiProtoPkg.sv
src/csiRxCfgPkg.sv
src/csiLaneCapture.sv
src/csiDualClkFifo.sv
src/csiLineCounter.sv
src/csiHeaderParser.sv
src/csiRxDecoder.sv
tb/tbCsiRx.sv

// ==== tb/tbCsiRx.sv ====
/* Directed testbench for the two-lane CSI-2 receiver. The byte clock is slower than
   iSCLK, so the FIFO never fills. Payload bytes come from a seeded $random */
`default_nettype none

module tbCsiRx;
	timeunit 1ns;
	timeprecision 1ps;

	import csiProtoPkg::*;
	import csiRxCfgPkg::*;

	localparam int ResetCycles	= 16;
	localparam int GapWords		= 2;							// Idle byte cycles after a packet
	localparam int DrainCycles	= 300;							// iSCLK limit per wait
	localparam int MarginNs		= 20000;
	localparam int RandPackets	= 10;

	logic					iSCLK		= 1'b0;
	logic					wordClk		= 1'b0;
	logic					qnHsRst		= 1'b0;
	logic [7:0]				lane0Data	= 8'h00;
	logic [7:0]				lane1Data	= 8'h00;
	logic					laneValid	= 1'b0;
	logic					laneSync	= 1'b0;
	logic [PixelBits-1:0]	pixel;
	logic [5:0]				dataType;
	logic [1:0]				virtChan;
	logic [15:0]			wordCnt;
	logic [7:0]				ecc;
	logic					pixelValid;
	logic					lineEnd;

	integer			seed = 32'he38e;
	logic [31:0]	expPix [$];									// Expected pixels in order
	bit				expLast [$];								// Last pixel of its line
	logic [15:0]	randWc [RandPackets];
	logic [1:0]		hdrVc;										// Header of last packet sent
	logic [5:0]		hdrDt;
	logic [15:0]	hdrWc;
	logic [7:0]		hdrEcc;
	int				errorCount, checkCount, pixelCount, lineCount, lineTarget;
	int				budgetNs;

	csiRxDecoder #(
		.pFifoDepth(1024),
		.pLineCntBits(13)
	) UUT (
		.wordClk(wordClk),		.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
		.lane0Data(lane0Data),	.lane1Data(lane1Data),
		.laneValid(laneValid),	.laneSync(laneSync),
		.pixel(pixel),			.dataType(dataType),	.virtChan(virtChan),
		.wordCnt(wordCnt),		.ecc(ecc),
		.pixelValid(pixelValid),	.lineEnd(lineEnd)
	);

	always #10 iSCLK = ~iSCLK;									// 20 ns system clock
	always #13 wordClk = ~wordClk;								// 26 ns, drifts against iSCLK

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			errorCount++;
		end
	endtask

	function automatic int packetWords(input int wc);
		return 3 + wc / 2 + GapWords;							// Sync, two header words, payload
	endfunction

	task automatic driveWord(input logic [7:0] l0, input logic [7:0] l1, input logic v, input logic s);
		@(posedge wordClk);
		lane0Data	<= l0;
		lane1Data	<= l1;
		laneValid	<= v;
		laneSync	<= s;
	endtask

	task automatic sendPacket(input logic [1:0] vc, input logic [5:0] dt, input logic [15:0] wc,
		input logic [7:0] ec);
		DataId			di;
		logic [31:0]	rnd;
		int				words;
		di.virtChan	= vc;
		di.dataType	= dt;
		hdrVc		= vc;
		hdrDt		= dt;
		hdrWc		= wc;
		hdrEcc		= ec;
		words		= int'(wc[15:1]);
		driveWord(8'h00, 8'h00, 1'b0, 1'b1);					// Sync marker cycle
		driveWord(di, wc[7:0], 1'b1, 1'b0);						// DI and WC LSB
		driveWord(wc[15:8], ec, 1'b1, 1'b0);					// WC MSB and ECC
		if (dt > LongPacketMin)
		begin
			lineTarget++;
			for (int n = 0; n < words; n++)
			begin
				rnd = $random(seed);
				expPix.push_back({16'h0000, rnd[15:8], rnd[7:0]});	// Lane 1 over lane 0
				expLast.push_back(n == words - 1);
				driveWord(rnd[7:0], rnd[15:8], 1'b1, 1'b0);
			end
		end
		repeat (GapWords) driveWord(8'h00, 8'h00, 1'b0, 1'b0);
	endtask

	// Wait for all queued pixels and line ends
	task automatic waitDrain();
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge iSCLK);
			cycles++;
		end
		while ((expPix.size() != 0 || lineCount != lineTarget) && cycles < DrainCycles);
		if (expPix.size() != 0 || lineCount != lineTarget)
		begin
			$display("Pixels missing at %0t ns: %0d still expected, %0d of %0d lines ended",
				$time, expPix.size(), lineCount, lineTarget);
			errorCount++;
		end
		@(negedge iSCLK);										// Outputs settled
	endtask

	task automatic waitHeader();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge iSCLK);
			cycles++;
		end
		while ({virtChan, dataType, wordCnt, ecc} != {hdrVc, hdrDt, hdrWc, hdrEcc}
			&& cycles < DrainCycles);
	endtask

	task automatic checkHeader();
		checkValue("virtChan", 32'(virtChan), 32'(hdrVc));
		checkValue("dataType", 32'(dataType), 32'(hdrDt));
		checkValue("wordCnt", 32'(wordCnt), 32'(hdrWc));
		checkValue("ecc", 32'(ecc), 32'(hdrEcc));
	endtask

	task automatic reportTest(input string name, input int errBefore);
		$display("Test %s: %s (%0d errors)", name,
			(errorCount == errBefore) ? "passed" : "failed", errorCount - errBefore);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic testHeaderDecode();
		int errBefore;
		errBefore = errorCount;
		sendPacket(2'd1, 6'h2B, 16'd12, 8'h5A);
		waitDrain();
		checkHeader();
		reportTest("header decode", errBefore);
	endtask

	task automatic testPayload();
		int errBefore, pixBefore;
		errBefore = errorCount;
		pixBefore = pixelCount;
		sendPacket(2'd0, 6'h1E, 16'd8, 8'h3C);					// YUV422, four words
		waitDrain();
		checkValue("pixel count", 32'(pixelCount - pixBefore), 32'd4);
		reportTest("payload forwarding", errBefore);
	endtask

	task automatic testLineEnd();
		int errBefore, linesBefore;
		errBefore = errorCount;
		linesBefore = lineCount;
		sendPacket(2'd0, 6'h2A, 16'd6, 8'h11);
		sendPacket(2'd2, 6'h2A, 16'd10, 8'h22);
		waitDrain();
		checkValue("lineEnd count", 32'(lineCount - linesBefore), 32'd2);
		reportTest("line end", errBefore);
	endtask

	task automatic testShortPacket();
		int errBefore, pixBefore;
		errBefore = errorCount;
		pixBefore = pixelCount;
		sendPacket(2'd0, 6'h00, 16'h0001, 8'h07);				// Frame start, frame 1
		waitHeader();
		checkHeader();
		checkValue("pixels after short packet", 32'(pixelCount - pixBefore), 32'd0);
		sendPacket(2'd3, 6'h24, 16'd16, 8'h6C);
		waitDrain();
		checkHeader();
		checkValue("pixel count", 32'(pixelCount - pixBefore), 32'd8);
		reportTest("short packet", errBefore);
	endtask

	task automatic testRandomLines();
		logic [31:0]	rnd;
		int				errBefore, pixBefore, wordsSent;
		errBefore = errorCount;
		pixBefore = pixelCount;
		wordsSent = 0;
		foreach (randWc[i])
		begin
			rnd = $random(seed);
			sendPacket(rnd[1:0], 6'h14 + 6'(rnd[6:2]), randWc[i], rnd[15:8]);	// Long types only
			wordsSent += int'(randWc[i][15:1]);
		end
		waitDrain();
		checkHeader();
		checkValue("pixel count", 32'(pixelCount - pixBefore), 32'(wordsSent));
		reportTest("random lines", errBefore);
	endtask

	// ----------------------------------------
	// Monitor, watchdog, main sequence
	// ----------------------------------------
	always @(negedge iSCLK)
	begin
		if (qnHsRst)
		begin
			if (pixelValid)
			begin
				pixelCount++;
				if (expPix.size() == 0)
				begin
					$display("Unexpected pixel %h at %0t ns, none was sent", pixel, $time);
					errorCount++;
				end
				else
				begin
					checkValue("pixel", pixel, expPix.pop_front());
					checkValue("lineEnd", 32'(lineEnd), 32'(expLast.pop_front()));
				end
			end
			else if (lineEnd)
			begin
				$display("lineEnd pulsed at %0t ns without a pixel", $time);
				errorCount++;
			end
			if (lineEnd)
				lineCount++;
		end
	end

	initial
	begin
		wait (budgetNs != 0);
		#(budgetNs);
		$display("Watchdog expired after %0d ns, the tests did not complete", budgetNs);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		logic [31:0]	rnd;
		int				budgetWords;
		budgetWords = packetWords(12) + packetWords(8) + packetWords(6) + packetWords(10)
			+ packetWords(0) + packetWords(16);
		foreach (randWc[i])
		begin
			rnd = $random(seed);
			randWc[i] = {10'd0, rnd[4:0], 1'b0} + 16'd2;		// Even, 2 to 64
			budgetWords += packetWords(int'(randWc[i]));
		end
		budgetNs = budgetWords * 40 + ResetCycles * 20 + MarginNs;

		repeat (ResetCycles) @(posedge iSCLK);
		qnHsRst <= 1'b1;
		repeat (4) @(posedge wordClk);

		testHeaderDecode();
		testPayload();
		testLineEnd();
		testShortPacket();
		testRandomLines();

		$display("Tests run: 5, checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : tbCsiRx

`default_nettype wire
